/* build.f */
+incdir+.
xain_pkg.sv
bridge_regs.sv
pll_reconfig.sv
video_timing_gen.sv
core_top.sv
core_top_tb.sv

/* core_top_tb.sv */
/*
  testbench for core_top, stimulus table applied in order after a 16 cycle reset
  pll port model keeps lock high and stalls with waitrequest at random
  video is checked every cycle against a raster model, run ends after two full frames
*/
`timescale 1ns/1ps
`default_nettype none
`include "xain_defines.svh"

module core_top_tb;

  import xain_pkg::*;

  typedef enum logic [1:0] {OP_READ, OP_WRITE, OP_KEYS, OP_RECONF} op_t;

  typedef struct packed {
    op_t         op;
    logic [31:0] addr;
    logic [31:0] data;       // write data, or target rate for OP_RECONF
    logic [31:0] expected;   // read-back value
  } step_t;

  localparam int N_STEPS     = 22;
  localparam int STEP_CYCLES = 1000;    // worst case per step, reconfig included
  localparam int WATCHDOG_CYCLES = 3 * 204800 + N_STEPS * STEP_CYCLES + 2000;

  // controller key bits
  localparam int K_UP = 0, K_DOWN = 1, K_LEFT = 2, K_RIGHT = 3;
  localparam int K_A = 4, K_B = 5, K_SELECT = 14, K_START = 15;

  localparam step_t STEPS [N_STEPS] = '{
    '{OP_READ,   `XAIN_ADDR_DIP,    32'h0,         32'h0000_FFFF},  // reset values
    '{OP_READ,   `XAIN_ADDR_MOD,    32'h0,         32'h0},
    '{OP_READ,   `XAIN_ADDR_STATUS, 32'h0,         32'h0},
    '{OP_WRITE,  `XAIN_ADDR_DIP,    32'h1234_A55A, 32'h0},
    '{OP_READ,   `XAIN_ADDR_DIP,    32'h0,         32'h0000_A55A},  // upper half dropped
    '{OP_WRITE,  `XAIN_ADDR_MOD,    32'h0000_00F3, 32'h0},          // bit 2 clear, no reconfig
    '{OP_READ,   `XAIN_ADDR_MOD,    32'h0,         32'h0000_00F3},
    '{OP_WRITE,  32'hF300_0000,     32'hFFFF_FFFF, 32'h0},          // unmapped
    '{OP_READ,   32'hF300_0000,     32'h0,         32'h0},
    '{OP_READ,   `XAIN_ADDR_DIP,    32'h0,         32'h0000_A55A},
    '{OP_READ,   `XAIN_ADDR_MOD,    32'h0,         32'h0000_00F3},
    '{OP_KEYS,   32'h0,             32'h0,         32'h0},
    '{OP_KEYS,   32'h0,             32'h0,         32'h0},
    '{OP_KEYS,   32'h0,             32'h0,         32'h0},
    '{OP_WRITE,  `XAIN_ADDR_MOD,    32'h0000_0004, 32'h0},          // ask for 60 Hz
    '{OP_RECONF, 32'h0,             32'h1,         32'h0},
    '{OP_READ,   `XAIN_ADDR_STATUS, 32'h0,         32'h0000_0002},
    '{OP_READ,   `XAIN_ADDR_MOD,    32'h0,         32'h0000_0004},
    '{OP_WRITE,  `XAIN_ADDR_MOD,    32'h0000_0000, 32'h0},          // back to 57 Hz
    '{OP_RECONF, 32'h0,             32'h0,         32'h0},
    '{OP_READ,   `XAIN_ADDR_STATUS, 32'h0,         32'h0},
    '{OP_KEYS,   32'h0,             32'h0,         32'h0}
  };

  // pll management tables, address list shared by both rates
  localparam logic [5:0] PLL_ADDR [9] = '{
    6'h00, 6'h04, 6'h03, 6'h05, 6'h05, 6'h05, 6'h05, 6'h08, 6'h02
  };
  localparam logic [31:0] PLL_57 [9] = '{
    32'h0, 32'h4040, 32'h20605, 32'h20504, 32'h40909, 32'h84848, 32'hC4848, 32'h2, 32'h0
  };
  localparam logic [31:0] PLL_60 [9] = '{
    32'h0, 32'h4F4F, 32'h20706, 32'h20504, 32'h40909, 32'h84848, 32'hC4848, 32'h3, 32'h0
  };

  logic         clk_74a = 1'b0;
  logic         reset_n = 1'b0;
  logic [31:0]  bridge_addr = 32'h0;
  logic         bridge_rd = 1'b0;
  logic         bridge_wr = 1'b0;
  logic [31:0]  bridge_wr_data = 32'h0;
  logic [15:0]  cont1_key = 16'h0;
  logic [15:0]  cont2_key = 16'h0;
  logic         pll_locked = 1'b1;            // lock held throughout
  logic         pll_mgmt_waitrequest = 1'b0;
  logic [31:0]  bridge_rd_data;
  pll_mgmt_wr_t pll_mgmt;
  logic [23:0]  video_rgb;
  logic         video_de, video_vs, video_hs;
  logic         core_pause;
  logic [7:0]   player1, player2;
  video_out_t   video_got;

  pll_mgmt_wr_t pll_seen [$];   // accepted management writes
  int err_word = 0, err_pll = 0, err_video = 0;
  int mx = 0, my = 0;           // raster model, counter value behind the outputs
  logic started = 1'b0, pause_prev = 1'b0, vs_seen = 1'b0;
  int frame_cycles = 0, hs_cnt = 0, de_cnt = 0, frames_checked = 0;

  assign video_got = {video_rgb, video_de, video_vs, video_hs};

  core_top core_top_inst (
    .clk_74a(clk_74a), .reset_n(reset_n),
    .bridge_addr(bridge_addr), .bridge_rd(bridge_rd), .bridge_wr(bridge_wr),
    .bridge_wr_data(bridge_wr_data), .bridge_rd_data(bridge_rd_data),
    .cont1_key(cont1_key), .cont2_key(cont2_key),
    .pll_locked(pll_locked), .pll_mgmt_waitrequest(pll_mgmt_waitrequest),
    .pll_mgmt(pll_mgmt), .video_rgb(video_rgb), .video_de(video_de),
    .video_vs(video_vs), .video_hs(video_hs), .core_pause(core_pause),
    .player1(player1), .player2(player2)
  );

  always #5 clk_74a = ~clk_74a;   // 100 MHz stand-in for 74.25

  ////////////////////////////////////////////////////////////////////////////
  // compare tasks and helpers

  task automatic check_word(input string what, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      err_word++;
      $display("FAILED %0t: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_pll(input string what, input pll_mgmt_wr_t got, input pll_mgmt_wr_t exp);
    if (got !== exp) begin
      err_pll++;
      $display("FAILED %0t: %s got wr %b addr %h data %h expected wr %b addr %h data %h",
               $time, what, got.write, got.address, got.data, exp.write, exp.address,
               exp.data);
    end
  endtask

  task automatic check_video(input video_out_t got, input video_out_t exp);
    if (got !== exp) begin
      err_video++;
      if (err_video <= 10) begin   // first ten mismatches only
        $display("FAILED %0t: video got %h/%b%b%b expected %h/%b%b%b at x %0d y %0d",
                 $time, got.rgb, got.de, got.vs, got.hs, exp.rgb, exp.de, exp.vs,
                 exp.hs, mx, my);
      end
    end
  endtask

  task automatic check_count(input string what, input int got, input int exp);
    if (got != exp) begin
      err_video++;
      $display("FAILED %0t: %s got %0d expected %0d", $time, what, got, exp);
    end
  endtask

  // active-low arcade bytes, {player2, player1}
  function automatic logic [15:0] map_player_bytes(input logic [15:0] c1, input logic [15:0] c2);
    logic [7:0] p1;
    logic [7:0] p2;
    p1 = ~{c2[K_START], c1[K_START], c1[K_B], c1[K_A],
           c1[K_DOWN], c1[K_UP], c1[K_LEFT], c1[K_RIGHT]};
    p2 = ~{c2[K_SELECT], c1[K_SELECT], c2[K_B], c2[K_A],
           c2[K_DOWN], c2[K_UP], c2[K_LEFT], c2[K_RIGHT]};
    return {p2, p1};
  endfunction

  function automatic pll_mgmt_wr_t expected_pll(input video_timing_t rate, input int idx);
    pll_mgmt_wr_t w;
    w.write   = 1'b1;
    w.address = PLL_ADDR[idx];
    w.data    = (rate == VIDEO_60HZ) ? PLL_60[idx] : PLL_57[idx];
    return w;
  endfunction

  task automatic bus_write(input logic [31:0] addr, input logic [31:0] data);
    @(posedge clk_74a);
    bridge_addr    <= addr;
    bridge_wr_data <= data;
    bridge_wr      <= 1'b1;
    @(posedge clk_74a);
    bridge_wr      <= 1'b0;   // one cycle strobe
  endtask

  task automatic bus_read(input logic [31:0] addr, input logic [31:0] exp);
    @(posedge clk_74a);
    bridge_addr <= addr;
    bridge_rd   <= 1'b1;
    @(posedge clk_74a);
    bridge_rd   <= 1'b0;
    @(negedge clk_74a);       // data registered on the edge after rd
    check_word($sformatf("read of %h", addr), bridge_rd_data, exp);
  endtask

  task automatic run_keys();
    logic [15:0] k1;
    logic [15:0] k2;
    logic [15:0] bytes;
    k1    = 16'($urandom);
    k2    = 16'($urandom);
    bytes = map_player_bytes(k1, k2);
    @(posedge clk_74a);
    cont1_key <= k1;
    cont2_key <= k2;
    @(negedge clk_74a);
    check_word("player outputs", {16'h0, player2, player1}, {16'h0, bytes});
    bus_read(`XAIN_ADDR_INPUTS, {16'h0, bytes});
  endtask

  // pause up, status mid-pause, pause down, then the nine writes in order
  task automatic run_reconfig(input video_timing_t rate);
    if (pll_seen.size() != 0) begin
      err_pll++;
      $display("pll writes seen outside a reconfiguration at %0t", $time);
    end
    wait (core_pause === 1'b1);
    bus_read(`XAIN_ADDR_STATUS, {30'd0, 1'(rate), 1'b1});
    wait (core_pause === 1'b0);
    @(negedge clk_74a);
    if (pll_seen.size() != 9) begin
      err_pll++;
      $display("reconfiguration issued %0d pll writes instead of 9", pll_seen.size());
    end
    for (int i = 0; i < pll_seen.size() && i < 9; i++) begin
      check_pll($sformatf("pll write %0d", i), pll_seen[i], expected_pll(rate, i));
    end
    pll_seen.delete();
  endtask

  task automatic print_summary();
    $display("errors: %0d bridge, %0d pll, %0d video over %0d frames",
             err_word, err_pll, err_video, frames_checked);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // pll port model and monitors

  always @(posedge clk_74a) begin
    if (reset_n) begin
      pll_mgmt_waitrequest <= ($urandom_range(3) == 0);  // stall about one in four
    end
  end

  always @(negedge clk_74a) begin
    if (reset_n && pll_mgmt.write) begin
      if (pll_mgmt_waitrequest || !pll_locked) begin
        err_pll++;
        $display("pll write raised during a stall at %0t", $time);
      end
      pll_seen.push_back(pll_mgmt);
    end
  end

  always @(negedge clk_74a) begin : video_monitor
    video_out_t expv;
    expv = '0;
    if (!reset_n) begin
      started    = 1'b0;
      pause_prev = 1'b0;
    end else begin
      if (started) begin     // first cycle out of reset still shows reset values
        expv.vs  = (mx == 0) && (my == 0);
        expv.hs  = (mx == `XAIN_HS_COLUMN);
        expv.de  = (mx >= `XAIN_H_BPORCH) && (mx < `XAIN_H_BPORCH + `XAIN_H_ACTIVE) &&
                   (my >= `XAIN_V_BPORCH) && (my < `XAIN_V_BPORCH + `XAIN_V_ACTIVE);
        expv.rgb = (expv.de && !pause_prev) ? {3{`XAIN_GREY_LEVEL}} : 24'h0;
        mx = (mx == `XAIN_H_TOTAL - 1) ? 0 : mx + 1;
        if (mx == 0) begin
          my = (my == `XAIN_V_TOTAL - 1) ? 0 : my + 1;
        end
      end
      started = 1'b1;
      check_video(video_got, expv);
      pause_prev = core_pause;     // rgb lags pause by one edge
      if (video_got.vs) begin
        if (vs_seen) begin
          check_count("cycles per frame", frame_cycles, 204800);
          check_count("hs pulses per frame", hs_cnt, 512);
          check_count("de cycles per frame", de_cnt, 76800);
          frames_checked++;
        end
        vs_seen      = 1'b1;
        frame_cycles = 1;
        hs_cnt       = video_got.hs;
        de_cnt       = video_got.de;
      end else begin
        frame_cycles++;
        hs_cnt += video_got.hs;
        de_cnt += video_got.de;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // main sequence and watchdog

  initial begin
    void'($urandom(22540));   // one seed for the whole run
    repeat (16) @(posedge clk_74a);
    reset_n <= 1'b1;
    @(negedge clk_74a);
    check_word("core_pause after reset", {31'd0, core_pause}, 32'h0);
    check_word("read data after reset", bridge_rd_data, 32'h0);
    check_pll("pll port after reset", pll_mgmt, '0);
    for (int s = 0; s < N_STEPS; s++) begin
      case (STEPS[s].op)
        OP_READ:   bus_read(STEPS[s].addr, STEPS[s].expected);
        OP_WRITE: begin
          if (STEPS[s].addr == `XAIN_ADDR_MOD) begin
            wait (video_de === 1'b1);   // pause then overlaps active video
          end
          bus_write(STEPS[s].addr, STEPS[s].data);
        end
        OP_KEYS:   run_keys();
        OP_RECONF: run_reconfig(video_timing_t'(STEPS[s].data[0]));
        default:   ;
      endcase
    end
    wait (frames_checked >= 2);
    @(negedge clk_74a);
    if (pll_seen.size() != 0) begin
      err_pll++;
      $display("pll writes seen after the last reconfiguration");
    end
    print_summary();
    if (err_word + err_pll + err_video == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_CYCLES * 10);
    $display("watchdog expired after %0d cycles, run did not complete", WATCHDOG_CYCLES);
    print_summary();
    $display("FAIL: see errors above");
    $finish;
  end

endmodule

`default_nettype wire

/* core_top.sv */
/*
  always-on host side of the xain arcade shell, single clk_74a domain
  pll output clocks and the game itself are outside this block
  player bytes are active low, controller keys active high
*/
`timescale 1ns/1ps
`default_nettype none

module core_top (
  input  wire                          clk_74a,
  input  wire                          reset_n,
  // host bridge
  input  wire [31:0]                   bridge_addr,
  input  wire                          bridge_rd,
  input  wire                          bridge_wr,
  input  wire [31:0]                   bridge_wr_data,
  output wire [31:0]                   bridge_rd_data,
  // controllers
  input  wire [15:0]                   cont1_key,
  input  wire [15:0]                   cont2_key,
  // pll management port
  input  wire                          pll_locked,
  input  wire                          pll_mgmt_waitrequest,
  output wire xain_pkg::pll_mgmt_wr_t  pll_mgmt,
  // video to scaler
  output wire [23:0]                   video_rgb,
  output wire                          video_de,
  output wire                          video_vs,
  output wire                          video_hs,
  // to the game core
  output wire                          core_pause,
  output wire [7:0]                    player1,
  output wire [7:0]                    player2
);

  import xain_pkg::*;

  bridge_req_t   bridge_req;
  switch_cfg_t   switches;
  video_timing_t timing_lat;
  video_out_t    video;
  wire           reconfig_pause;

  // pack the bridge
  assign bridge_req.address = bridge_addr;
  assign bridge_req.rd      = bridge_rd;
  assign bridge_req.wr      = bridge_wr;
  assign bridge_req.wr_data = bridge_wr_data;

  ////////////////////////////////////////////////////////////////////////////
  // player bytes, key bits 0 up 1 down 2 left 3 right 4 a 5 b 14 select 15 start

  assign player1 = ~{cont2_key[15], cont1_key[15], cont1_key[5], cont1_key[4],
                     cont1_key[1],  cont1_key[0],  cont1_key[2], cont1_key[3]};
  assign player2 = ~{cont2_key[14], cont1_key[14], cont2_key[5], cont2_key[4],
                     cont2_key[1],  cont2_key[0],  cont2_key[2], cont2_key[3]};

  bridge_regs bridge_regs_inst (
    .clk_74a        (clk_74a),
    .reset_n        (reset_n),
    .bridge         (bridge_req),
    .player1        (player1),
    .player2        (player2),
    .reconfig_pause (reconfig_pause),
    .timing_lat     (timing_lat),
    .bridge_rd_data (bridge_rd_data),
    .switches       (switches)
  );

  pll_reconfig pll_reconfig_inst (
    .clk_74a              (clk_74a),
    .reset_n              (reset_n),
    .switches             (switches),
    .pll_locked           (pll_locked),
    .pll_mgmt_waitrequest (pll_mgmt_waitrequest),
    .pll_mgmt             (pll_mgmt),
    .reconfig_pause       (reconfig_pause),
    .timing_lat           (timing_lat)
  );

  video_timing_gen video_timing_gen_inst (
    .clk_74a        (clk_74a),
    .reset_n        (reset_n),
    .reconfig_pause (reconfig_pause),
    .video          (video)
  );

  // unpack video, pause goes straight out
  assign video_rgb  = video.rgb;
  assign video_de   = video.de;
  assign video_vs   = video.vs;
  assign video_hs   = video.hs;
  assign core_pause = reconfig_pause;

endmodule

`default_nettype wire

/* video_timing_gen.sv */
/*
  320x240 active area in a 400x512 raster, flat grey field
  outputs are registered one cycle behind the counters
  black whenever reconfig_pause is high
*/
`timescale 1ns/1ps
`default_nettype none
`include "xain_defines.svh"

module video_timing_gen (
  input  wire                    clk_74a,
  input  wire                    reset_n,
  input  wire                    reconfig_pause,
  output xain_pkg::video_out_t   video
);

  import xain_pkg::*;

  logic [9:0] x_cnt;     // column, 0 .. 399
  logic [9:0] y_cnt;     // line, 0 .. 511
  logic       h_active;
  logic       v_active;
  logic       line_end;

  assign line_end = (x_cnt == `XAIN_H_TOTAL - 10'd1);

  assign h_active = (x_cnt >= `XAIN_H_BPORCH) &&
                    (x_cnt <  `XAIN_H_BPORCH + `XAIN_H_ACTIVE);
  assign v_active = (y_cnt >= `XAIN_V_BPORCH) &&
                    (y_cnt <  `XAIN_V_BPORCH + `XAIN_V_ACTIVE);

  ////////////////////////////////////////////////////////////////////////////
  // raster counters

  always_ff @(posedge clk_74a or negedge reset_n) begin
    if (!reset_n) begin
      x_cnt <= 10'd0;
      y_cnt <= 10'd0;
    end else begin
      if (line_end) begin
        x_cnt <= 10'd0;
        if (y_cnt == `XAIN_V_TOTAL - 10'd1) begin
          y_cnt <= 10'd0;              // wrap to new frame
        end else begin
          y_cnt <= y_cnt + 10'd1;
        end
      end else begin
        x_cnt <= x_cnt + 10'd1;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // sync, enable and pixel

  always_ff @(posedge clk_74a or negedge reset_n) begin
    if (!reset_n) begin
      video <= '0;
    end else begin
      // frame start pulse
      video.vs <= (x_cnt == 10'd0) && (y_cnt == 10'd0);
      // line pulse, a few clocks after vs
      video.hs <= (x_cnt == `XAIN_HS_COLUMN);
      video.de <= h_active && v_active;
      if (h_active && v_active && !reconfig_pause) begin
        video.rgb <= {3{`XAIN_GREY_LEVEL}};
      end else begin
        video.rgb <= 24'h000000;   // blanking and pause are black
      end
    end
  end

  // hs column keeps the two pulses apart
  a_no_sync_overlap : assert property (
    @(posedge clk_74a) disable iff (!reset_n)
    !(video.vs && video.hs)
  ) else $error("vs and hs in same cycle");

endmodule

`default_nettype wire

/* pll_reconfig.sv */
/*
  refresh rate reconfiguration of the core pll through its management port
  write is combinational and only raised in unstalled, locked cycles
  a rate change during the settle wait restarts the wait
*/
`timescale 1ns/1ps
`default_nettype none
`include "xain_defines.svh"

module pll_reconfig (
  input  wire                           clk_74a,
  input  wire                           reset_n,
  input  wire xain_pkg::switch_cfg_t    switches,
  input  wire                           pll_locked,
  input  wire                           pll_mgmt_waitrequest,
  output xain_pkg::pll_mgmt_wr_t        pll_mgmt,
  output logic                          reconfig_pause,
  output xain_pkg::video_timing_t       timing_lat
);

  import xain_pkg::*;

  ////////////////////////////////////////////////////////////////////////////
  // parameter tables, same address list for both rates

  localparam logic [5:0] PLL_ADDR [`XAIN_PLL_PARAM_COUNT] = '{
    6'h00, 6'h04, 6'h03, 6'h05, 6'h05, 6'h05, 6'h05, 6'h08, 6'h02
  };

  // mode, m, n, c0..c3, bandwidth, start
  localparam logic [31:0] PLL_DATA_57 [`XAIN_PLL_PARAM_COUNT] = '{
    32'h0, 32'h4040, 32'h20605, 32'h20504, 32'h40909,
    32'h84848, 32'hC4848, 32'h2, 32'h0
  };

  localparam logic [31:0] PLL_DATA_60 [`XAIN_PLL_PARAM_COUNT] = '{
    32'h0, 32'h4F4F, 32'h20706, 32'h20504, 32'h40909,
    32'h84848, 32'hC4848, 32'h3, 32'h0
  };

  video_timing_t timing_req;   // what the host asks for
  logic [7:0]    settle_cnt;   // 0 idle, counts up to the settle value
  logic [3:0]    param_idx;    // next table entry
  logic          write_phase;
  logic          unstalled;

  assign timing_req  = video_timing_t'(switches.mod_sw0[2]);
  assign write_phase = (settle_cnt == `XAIN_PLL_SETTLE_CYCLES);
  assign unstalled   = pll_locked & ~pll_mgmt_waitrequest;

  ////////////////////////////////////////////////////////////////////////////
  // sequencer

  always_ff @(posedge clk_74a or negedge reset_n) begin
    if (!reset_n) begin
      timing_lat     <= VIDEO_57HZ;
      settle_cnt     <= 8'd0;
      param_idx      <= 4'd0;
      reconfig_pause <= 1'b0;
    end else if (unstalled) begin   // stalled cycles freeze everything
      if (write_phase) begin
        param_idx <= param_idx + 4'd1;
        if (param_idx == `XAIN_PLL_PARAM_COUNT - 4'd1) begin
          settle_cnt <= 8'd0;       // last pair goes out this cycle
          param_idx  <= 4'd0;
        end
      end else if (timing_req != timing_lat) begin
        timing_lat     <= timing_req;   // new rate requested
        settle_cnt     <= 8'd1;
        param_idx      <= 4'd0;
        reconfig_pause <= 1'b1;
      end else if (settle_cnt != 8'd0) begin
        settle_cnt <= settle_cnt + 8'd1;  // let the core go quiet
      end else begin
        reconfig_pause <= 1'b0;     // done, pll locked again
      end
    end
  end

  // management write, one per unstalled cycle of the write phase
  always_comb begin
    pll_mgmt.write   = write_phase & unstalled;
    pll_mgmt.address = PLL_ADDR[param_idx];
    if (timing_lat == VIDEO_60HZ) begin
      pll_mgmt.data = PLL_DATA_60[param_idx];
    end else begin
      pll_mgmt.data = PLL_DATA_57[param_idx];
    end
  end

  // writes only go out unstalled and while the core is held
  a_no_write_in_stall : assert property (
    @(posedge clk_74a) disable iff (!reset_n)
    pll_mgmt.write |-> (reconfig_pause && !pll_mgmt_waitrequest)
  ) else $error("pll write during waitrequest or outside pause");

  a_idx_in_range : assert property (
    @(posedge clk_74a) disable iff (!reset_n)
    param_idx < `XAIN_PLL_PARAM_COUNT
  ) else $error("pll param index out of range");

endmodule

`default_nettype wire

/* bridge_regs.sv */
/*
  host bridge register block, one cycle strobes, full address match
  read data is registered and holds until the next rd strobe
  rd and wr must never be issued in the same cycle
*/
`timescale 1ns/1ps
`default_nettype none
`include "xain_defines.svh"

module bridge_regs (
  input  wire                           clk_74a,
  input  wire                           reset_n,
  input  wire xain_pkg::bridge_req_t    bridge,
  input  wire [7:0]                     player1,         // active low
  input  wire [7:0]                     player2,         // active low
  input  wire                           reconfig_pause,
  input  wire xain_pkg::video_timing_t  timing_lat,
  output logic [31:0]                   bridge_rd_data,
  output xain_pkg::switch_cfg_t         switches
);

  import xain_pkg::*;

  logic [31:0] rd_mux;     // read word for the current address
  logic        hit_dip;
  logic        hit_mod;

  assign hit_dip = (bridge.address == `XAIN_ADDR_DIP);
  assign hit_mod = (bridge.address == `XAIN_ADDR_MOD);

  ////////////////////////////////////////////////////////////////////////////
  // switch registers

  always_ff @(posedge clk_74a or negedge reset_n) begin
    if (!reset_n) begin
      switches.dip_sw0 <= `XAIN_DIP_RESET;
      switches.dip_sw1 <= `XAIN_DIP_RESET;
      switches.mod_sw0 <= `XAIN_MOD_RESET;
    end else if (bridge.wr) begin
      if (hit_dip) begin
        switches.dip_sw0 <= bridge.wr_data[7:0];
        switches.dip_sw1 <= bridge.wr_data[15:8];
      end
      if (hit_mod) begin
        switches.mod_sw0 <= bridge.wr_data[7:0];  // rate change picked up next cycle
      end
      // anything else on a write is dropped
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // read back

  always_comb begin
    case (bridge.address)
      `XAIN_ADDR_DIP: begin
        rd_mux = {16'h0000, switches.dip_sw1, switches.dip_sw0};
      end
      `XAIN_ADDR_MOD: begin
        rd_mux = {24'h000000, switches.mod_sw0};
      end
      `XAIN_ADDR_INPUTS: begin
        rd_mux = {16'h0000, player2, player1};   // raw arcade bytes
      end
      `XAIN_ADDR_STATUS: begin
        // bit 0 pause, bit 1 latched rate
        rd_mux = {30'd0, 1'(timing_lat), reconfig_pause};
      end
      default: begin
        rd_mux = 32'h0000_0000;                 // unmapped reads as zero
      end
    endcase
  end

  always_ff @(posedge clk_74a or negedge reset_n) begin
    if (!reset_n) begin
      bridge_rd_data <= 32'h0000_0000;
    end else if (bridge.rd) begin
      bridge_rd_data <= rd_mux;  // valid the cycle after rd
    end
  end

  // host never overlaps the two strobes
  a_no_rd_wr_overlap : assert property (
    @(posedge clk_74a) disable iff (!reset_n)
    !(bridge.rd && bridge.wr)
  ) else $error("bridge rd and wr high together");

endmodule

`default_nettype wire

/* xain_pkg.sv */
/*
  types shared by the xain host shell blocks
  field order inside each struct is the packing order on the wires
*/
`default_nettype none

package xain_pkg;

  // host bridge request, one strobe per access
  typedef struct packed {
    logic [31:0] address;
    logic        rd;       // one cycle read strobe
    logic        wr;       // one cycle write strobe
    logic [31:0] wr_data;
  } bridge_req_t;          // 66 bits

  // settings written by the host
  typedef struct packed {
    logic [7:0] dip_sw0;
    logic [7:0] dip_sw1;
    logic [7:0] mod_sw0;   // bit 2 picks the refresh rate
  } switch_cfg_t;

  // refresh rate, carried by modifier bit 2
  typedef enum logic {
    VIDEO_57HZ = 1'b0,
    VIDEO_60HZ = 1'b1
  } video_timing_t;

  // write side of the pll reconfig management port
  typedef struct packed {
    logic        write;    // only valid with waitrequest low
    logic [5:0]  address;
    logic [31:0] data;
  } pll_mgmt_wr_t;

  // video toward the scaler
  typedef struct packed {
    logic [23:0] rgb;      // r in 23:16, b in 7:0
    logic        de;
    logic        vs;
    logic        hs;
  } video_out_t;

endpackage

`default_nettype wire

/* xain_defines.svh */
/*
  shared constants for the xain host shell, all on clk_74a
  bridge addresses are compared on the full 32 bits, no wildcards
  raster numbers assume a 12.288 MHz pixel clock in the real core
*/
`ifndef XAIN_DEFINES_SVH
`define XAIN_DEFINES_SVH

////////////////////////////////////////////////////////////////////////////
// bridge map

`define XAIN_ADDR_DIP     32'hF100_0000  // dip switch bytes 0 and 1
`define XAIN_ADDR_MOD     32'hF200_0000  // modifier byte 0
`define XAIN_ADDR_STATUS  32'hFA00_0000  // pause and rate, read only
`define XAIN_ADDR_INPUTS  32'hFC00_0000  // player bytes, read only

`define XAIN_DIP_RESET    8'hFF          // all dips off (active low)
`define XAIN_MOD_RESET    8'h00

////////////////////////////////////////////////////////////////////////////
// raster, 400 x 512 = 204800 clocks per frame

`define XAIN_H_TOTAL      10'd400
`define XAIN_H_ACTIVE     10'd320
`define XAIN_H_BPORCH     10'd10
`define XAIN_V_TOTAL      10'd512
`define XAIN_V_ACTIVE     10'd240
`define XAIN_V_BPORCH     10'd10
`define XAIN_HS_COLUMN    10'd3          // keeps hs off the vs cycle
`define XAIN_GREY_LEVEL   8'd60          // per colour channel

// pll management sequence
`define XAIN_PLL_PARAM_COUNT    4'd9     // address/data pairs per table
`define XAIN_PLL_SETTLE_CYCLES  8'd255   // pause before first write

`endif
